//--- acq_pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Acquisition side: board and channel geometry, sample words
////////////////////////////////////////////////////////////////////////////

package acq_pkg;

	localparam int NUM_BOARDS   = 4;  // One reorder buffer per board
	localparam int BOARD_W      = 2;  // Width of a board index
	localparam int NUM_CHANNELS = 8;  // Channel words in one frame
	localparam int CHAN_W       = 3;  // Width of a channel index
	localparam int SAMPLE_W     = 32; // Width of one sample word

	// A tagged sample as it arrives from the front end
	typedef struct packed
	{
		logic [BOARD_W-1:0]  board;   // Which board the sample belongs to
		logic [CHAN_W-1:0]   channel; // Channel within that board
		logic [SAMPLE_W-1:0] data;    // The sample value itself
	} sample_t;

	// What a reorder buffer needs once the board has been decoded
	typedef struct packed
	{
		logic [CHAN_W-1:0]   channel; // Slot to store into
		logic [SAMPLE_W-1:0] data;
	} chan_word_t;

endpackage

`default_nettype wire

//--- mem_pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Memory side: DRAM address layout and the Wishbone classic port
////////////////////////////////////////////////////////////////////////////

package mem_pkg;

	localparam int OFFSET_W = 8;                 // Frame offset per board, wraps at 256
	localparam int DAT_W    = acq_pkg::SAMPLE_W; // One sample per bus word

	// DRAM word address, board in the top bits so each board owns a region
	typedef struct packed
	{
		logic [acq_pkg::BOARD_W-1:0] board;
		logic [acq_pkg::CHAN_W-1:0]  channel;
		logic [OFFSET_W-1:0]         offset;  // Counts the frames written for this board
	} dram_addr_t;

	// Master to slave half of the bus
	typedef struct packed
	{
		logic             cyc; // Held across a whole frame
		logic             stb; // One word request
		logic             we;  // Always a write here
		dram_addr_t       adr;
		logic [DAT_W-1:0] dat;
	} wb_req_t;

	// Slave to master half, classic cycles need only the acknowledge
	typedef struct packed
	{
		logic ack;
	} wb_rsp_t;

endpackage

`default_nettype wire

//--- sample_distributor.sv
`timescale 1ns/1ps
`default_nettype none

// Steers each accepted sample to the buffer of its board
module sample_distributor
(
	input  wire logic                             clk,
	input  wire logic                             rst_n,
	input  wire acq_pkg::sample_t                 sample_in,
	input  wire logic                             sample_valid,
	output logic                                  sample_ready,
	input  wire logic [acq_pkg::NUM_BOARDS-1:0]   buf_full,
	output logic [acq_pkg::NUM_BOARDS-1:0]        buf_wr,
	output acq_pkg::chan_word_t                   wr_word
);

	logic accept; // Sample handshake completes on this edge

	////////////////////////////////////////////////////////////////////////////
	// Flow control
	////////////////////////////////////////////////////////////////////////////

	// A board whose buffer holds a finished frame must not take new samples.
	// The write strobe still in flight is blocked as well, since the full flag
	// of a buffer only shows the effect of a write one edge after the strobe
	assign sample_ready = !buf_full[sample_in.board] && !buf_wr[sample_in.board];

	assign accept = sample_valid && sample_ready;

	////////////////////////////////////////////////////////////////////////////
	// Registered write toward the buffers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			buf_wr <= '0;                      // No buffer is written out of reset
		else
		begin
			buf_wr <= '0;                      // Strobes last one cycle
			if (accept)
				buf_wr[sample_in.board] <= 1'b1; // One-hot by board
		end
	end

	// Channel and data are shared by all buffers, only the strobe selects one
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			wr_word.channel <= sample_in.channel;
			wr_word.data    <= sample_in.data;
		end
	end

endmodule

`default_nettype wire

//--- reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

// Gathers one frame of channel words in arrival order and hands them out by channel
module reorder_buffer
(
	input  wire logic                          clk,
	input  wire logic                          rst_n,
	input  wire logic                          wr,
	input  wire acq_pkg::chan_word_t           wr_word,
	input  wire logic                          pop,
	output logic                               full,
	output logic                               ready,
	output logic [acq_pkg::SAMPLE_W-1:0]       head
);

	logic [acq_pkg::SAMPLE_W-1:0]     slot [acq_pkg::NUM_CHANNELS]; // One word per channel
	logic [acq_pkg::NUM_CHANNELS-1:0] fill_mask;  // Channels already stored
	logic [acq_pkg::NUM_CHANNELS-1:0] wr_onehot;  // Channel being stored this cycle
	logic [acq_pkg::NUM_CHANNELS-1:0] mask_next;  // Mask including the current write
	logic [acq_pkg::CHAN_W-1:0]       rd_ptr;     // Next channel to hand out
	logic                             frame_done; // All channels present, not drained yet

	////////////////////////////////////////////////////////////////////////////
	// Fill side
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		wr_onehot = '0;
		wr_onehot[wr_word.channel] = wr; // Marks the slot taken by this write
		mask_next = fill_mask | wr_onehot;
	end

	// Storage has no reset, the mask says which slots are meaningful
	always_ff @(posedge clk)
	begin
		if (wr)
			slot[wr_word.channel] <= wr_word.data;
	end

	////////////////////////////////////////////////////////////////////////////
	// Frame state and drain pointer
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			fill_mask  <= '0;
			rd_ptr     <= '0;
			frame_done <= 1'b0;
		end
		else if (pop && frame_done)
		begin
			rd_ptr <= rd_ptr + 1'b1;   // Wraps back to channel 0 after the last one
			if (&rd_ptr)               // Eighth pop ends the frame
			begin
				fill_mask  <= '0;
				frame_done <= 1'b0;
			end
		end
		else if (wr)
		begin
			fill_mask  <= mask_next;
			frame_done <= &mask_next;  // Completes on the edge of the last write
		end
	end

	// Both flags mark the same condition: a complete frame still in the buffer
	assign full  = frame_done;
	assign ready = frame_done;
	assign head  = slot[rd_ptr];   // Word for the current channel, in ascending order

endmodule

`default_nettype wire

//--- rr_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

// Rotating priority among the buffers that hold a complete frame
module rr_arbiter
(
	input  wire logic                             clk,
	input  wire logic                             rst_n,
	input  wire logic [acq_pkg::NUM_BOARDS-1:0]   req_mask,
	input  wire logic                             advance,
	output logic                                  grant_valid,
	output logic [acq_pkg::BOARD_W-1:0]           grant
);

	logic [acq_pkg::BOARD_W-1:0] last_grant; // Board served most recently

	// Search starts just after the last winner and wraps around.
	// The board count is a power of two, so the index add wraps by itself
	always_comb
	begin
		logic [acq_pkg::BOARD_W-1:0] cand;
		grant_valid = 1'b0;
		grant       = '0;
		cand        = '0;
		for (int i = 1; i <= acq_pkg::NUM_BOARDS; i++)
		begin
			cand = last_grant + i[acq_pkg::BOARD_W-1:0];
			if (!grant_valid && req_mask[cand]) // First hit in rotation order wins
			begin
				grant_valid = 1'b1;
				grant       = cand;
			end
		end
	end

	// Pointer starts at the top board so that board 0 gets first pick
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			last_grant <= '1;
		else if (advance && grant_valid)
			last_grant <= grant; // Only moves when the controller takes the grant
	end

endmodule

`default_nettype wire

//--- dram_write_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

// Drains complete frames from the buffers onto a Wishbone classic master
module dram_write_ctrl
(
	input  wire logic                                                 clk,
	input  wire logic                                                 rst_n,
	input  wire logic [acq_pkg::NUM_BOARDS-1:0]                       buf_ready,
	input  wire logic [acq_pkg::NUM_BOARDS-1:0][acq_pkg::SAMPLE_W-1:0] buf_head,
	output logic [acq_pkg::NUM_BOARDS-1:0]                            buf_pop,
	output mem_pkg::wb_req_t                                          wb_req,
	input  wire mem_pkg::wb_rsp_t                                     wb_rsp
);

	typedef enum logic [1:0]
	{
		ARBITRATE, // Waiting for a buffer with a complete frame
		WRITE,     // stb high, waiting for ack
		GAP,       // stb low for one cycle while the buffer head moves on
		SETTLE     // Frame done, let the buffer drop ready before the next pick
	} state_t;

	state_t                       state;
	logic [acq_pkg::BOARD_W-1:0]  sel_board;  // Board being drained
	logic [acq_pkg::CHAN_W-1:0]   chan;       // Channel of the word on the bus
	logic [mem_pkg::OFFSET_W-1:0] offset [acq_pkg::NUM_BOARDS]; // Next frame slot per board

	logic                         grant_valid;
	logic [acq_pkg::BOARD_W-1:0]  grant;
	logic                         advance;    // Arbiter pointer update

	////////////////////////////////////////////////////////////////////////////
	// Board selection
	////////////////////////////////////////////////////////////////////////////

	rr_arbiter u_arb
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.req_mask    (buf_ready),
		.advance     (advance),
		.grant_valid (grant_valid),
		.grant       (grant)
	);

	assign advance = (state == ARBITRATE) && grant_valid; // Taken the same cycle it is offered

	////////////////////////////////////////////////////////////////////////////
	// Frame drain FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state     <= ARBITRATE;
			sel_board <= '0;
			chan      <= '0;
			for (int b = 0; b < acq_pkg::NUM_BOARDS; b++)
				offset[b] <= '0;             // Every board starts at frame slot 0
		end
		else
		begin
			case (state)
				ARBITRATE:
				begin
					if (grant_valid)
					begin
						sel_board <= grant;    // Latch the winner for the whole frame
						chan      <= '0;       // Frames always leave in channel order
						state     <= WRITE;
					end
				end
				WRITE:
				begin
					if (wb_rsp.ack)
					begin
						if (&chan)             // Last channel acknowledged
						begin
							offset[sel_board] <= offset[sel_board] + 1'b1; // Wraps at 256
							state             <= SETTLE;
						end
						else
						begin
							chan  <= chan + 1'b1;
							state <= GAP;
						end
					end
				end
				GAP:
					state <= WRITE;              // Head already shows the next channel
				SETTLE:
					state <= ARBITRATE;          // Buffer ready is low again by now
				default:
					state <= ARBITRATE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Bus and pop outputs, decoded from the state
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		wb_req.cyc         = (state == WRITE) || (state == GAP); // Spans the frame
		wb_req.stb         = (state == WRITE);
		wb_req.we          = 1'b1;                               // Write-only master
		wb_req.adr.board   = sel_board;
		wb_req.adr.channel = chan;
		wb_req.adr.offset  = offset[sel_board];
		wb_req.dat         = buf_head[sel_board]; // Held until ack, the head only moves on pop

		// Each acknowledged word releases the slot it came from
		buf_pop = '0;
		if ((state == WRITE) && wb_rsp.ack)
			buf_pop[sel_board] = 1'b1;
	end

endmodule

`default_nettype wire

//--- acq_top.sv
`timescale 1ns/1ps
`default_nettype none

// Sample storage path: distributor, per-board reorder buffers, DRAM writer
module acq_top
(
	input  wire logic               clk,
	input  wire logic               rst_n,
	input  wire acq_pkg::sample_t   sample_in,
	input  wire logic               sample_valid,
	output logic                    sample_ready,
	output mem_pkg::wb_req_t        wb_req,
	input  wire mem_pkg::wb_rsp_t   wb_rsp
);

	logic [acq_pkg::NUM_BOARDS-1:0]                        buf_wr;    // Write strobe per buffer
	logic [acq_pkg::NUM_BOARDS-1:0]                        buf_full;  // Buffer holds a frame
	logic [acq_pkg::NUM_BOARDS-1:0]                        buf_ready; // Frame ready to drain
	logic [acq_pkg::NUM_BOARDS-1:0]                        buf_pop;   // One-hot drain step
	logic [acq_pkg::NUM_BOARDS-1:0][acq_pkg::SAMPLE_W-1:0] buf_head;
	acq_pkg::chan_word_t                                   wr_word;   // Shared by all buffers

	sample_distributor u_dist
	(
		.clk          (clk),
		.rst_n        (rst_n),
		.sample_in    (sample_in),
		.sample_valid (sample_valid),
		.sample_ready (sample_ready),
		.buf_full     (buf_full),
		.buf_wr       (buf_wr),
		.wr_word      (wr_word)
	);

	// One buffer per board
	for (genvar g = 0; g < acq_pkg::NUM_BOARDS; g++)
	begin : g_buf
		reorder_buffer u_buf
		(
			.clk     (clk),
			.rst_n   (rst_n),
			.wr      (buf_wr[g]),
			.wr_word (wr_word),
			.pop     (buf_pop[g]),
			.full    (buf_full[g]),
			.ready   (buf_ready[g]),
			.head    (buf_head[g])
		);
	end

	dram_write_ctrl u_ctrl
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.buf_ready (buf_ready),
		.buf_head  (buf_head),
		.buf_pop   (buf_pop),
		.wb_req    (wb_req),
		.wb_rsp    (wb_rsp)
	);

endmodule

`default_nettype wire

//--- acq_properties.sv
`timescale 1ns/1ps
`default_nettype none

// Bus protocol and drain checks inside the DRAM write controller
module acq_properties
(
	input wire logic                           clk,
	input wire logic                           rst_n,
	input wire mem_pkg::wb_req_t               wb_req,
	input wire mem_pkg::wb_rsp_t               wb_rsp,
	input wire logic [acq_pkg::NUM_BOARDS-1:0] buf_pop
);

	// A strobe only ever appears inside a bus cycle
	a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
		wb_req.stb |-> wb_req.cyc)
		else $error("wb stb high while cyc is low");

	a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(wb_req.stb && !wb_rsp.ack) |=> ($stable(wb_req.adr) && $stable(wb_req.dat)))
		else $error("wb adr or dat changed before ack"); // Slave may sample any cycle

	a_write_only: assert property (@(posedge clk) disable iff (!rst_n)
		wb_req.cyc |-> wb_req.we)
		else $error("wb cycle without we");

	// At most one buffer advances per edge
	a_pop_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(buf_pop))
		else $error("more than one buffer popped in one cycle");

endmodule

bind dram_write_ctrl acq_properties u_props
(
	.clk     (clk),
	.rst_n   (rst_n),
	.wb_req  (wb_req),
	.wb_rsp  (wb_rsp),
	.buf_pop (buf_pop)
);

`default_nettype wire

//--- tb_acq_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_acq_top;

	localparam int CLK_PERIOD = 8;
	localparam int NUM_ROWS   = 10;

	// One row is one frame for one board
	typedef struct packed
	{
		logic [acq_pkg::BOARD_W-1:0]  board;
		logic [acq_pkg::SAMPLE_W-1:0] base;  // Channel c carries base + c
		int                           delay; // Wait cycles before each ack of this frame
		logic                         hold;  // Ack held off while this frame loads
	} row_t;

	// One bus write the DUT owes us
	typedef struct packed
	{
		mem_pkg::dram_addr_t          adr;
		logic [acq_pkg::SAMPLE_W-1:0] dat;
		int                           delay;
	} exp_word_t;

	// Held rows come first with distinct boards, the rest reload boards that may still drain
	localparam row_t STIM [NUM_ROWS] = '{
		'{2'd2, 32'h2000_0000, 1, 1'b1},
		'{2'd0, 32'h0000_1000, 2, 1'b1},
		'{2'd3, 32'h3000_0100, 0, 1'b1},
		'{2'd1, 32'h1000_0040, 1, 1'b1},
		'{2'd0, 32'h0000_2000, 6, 1'b0},
		'{2'd0, 32'h0000_3000, 7, 1'b0},
		'{2'd3, 32'h3000_0200, 3, 1'b0},
		'{2'd2, 32'h2000_0300, 0, 1'b0},
		'{2'd1, 32'h1000_0400, 5, 1'b0},
		'{2'd1, 32'h1000_0500, 2, 1'b0}
	};

	logic                           clk = 1'b0;
	logic                           rst_n;
	acq_pkg::sample_t               sample_in;
	logic                           sample_valid;
	logic                           sample_ready;
	mem_pkg::wb_req_t               wb_req;
	mem_pkg::wb_rsp_t               wb_rsp = '0;
	logic                           hold_ack;        // Slave ignores stb while set
	logic [7:0]                     lfsr_state = 8'd31;
	logic [acq_pkg::CHAN_W-1:0]     chan_order [acq_pkg::NUM_CHANNELS]; // Send order of a frame
	logic [mem_pkg::OFFSET_W-1:0]   exp_off [acq_pkg::NUM_BOARDS];
	exp_word_t                      exp_q [acq_pkg::NUM_BOARDS][$];      // Scoreboard per board
	logic [acq_pkg::BOARD_W-1:0]    start_order [$]; // Board of each frame as its drain begins
	int                             wait_cnt = 0;
	int                             word_checks = 0;
	int                             word_errs = 0;
	int                             frame_errs = 0;
	int                             frames = 0;
	int                             test_checks = 0;
	int                             test_errs = 0;
	int                             stall_cycles = 0; // Cycles samples waited on a full buffer
	int                             cycles = 0;
	int                             cycle_limit;

	acq_top uut
	(
		.clk          (clk),
		.rst_n        (rst_n),
		.sample_in    (sample_in),
		.sample_valid (sample_valid),
		.sample_ready (sample_ready),
		.wb_req       (wb_req),
		.wb_rsp       (wb_rsp)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	// x^8 + x^6 + x^5 + x^4 + 1, new bit enters at the bottom
	function automatic logic [7:0] lfsr_next(input logic [7:0] s);
		return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
	endfunction

	task automatic draw_bits(input int n, output int value);
		value = 0;
		for (int k = 0; k < n; k++)
		begin
			lfsr_state = lfsr_next(lfsr_state); // One step per bit taken
			value      = value * 2 + int'(lfsr_state[0]);
		end
	endtask

	// Fisher-Yates over the eight channels
	task automatic shuffle_channels();
		int                         pick;
		logic [acq_pkg::CHAN_W-1:0] tmp;
		for (int c = 0; c < acq_pkg::NUM_CHANNELS; c++)
			chan_order[c] = c[acq_pkg::CHAN_W-1:0];
		for (int i = acq_pkg::NUM_CHANNELS - 1; i > 0; i--)
		begin
			draw_bits(3, pick);
			pick           = pick % (i + 1);
			tmp            = chan_order[i];
			chan_order[i]  = chan_order[pick];
			chan_order[pick] = tmp;
		end
	endtask

	// Lowest board above the last one served, wrapping around
	function automatic logic [acq_pkg::BOARD_W-1:0] rotate_pick(
		input logic [acq_pkg::BOARD_W-1:0]    last,
		input logic [acq_pkg::NUM_BOARDS-1:0] mask);
		logic [acq_pkg::BOARD_W-1:0] cand;
		logic [acq_pkg::BOARD_W-1:0] pick;
		pick = last;
		for (int i = acq_pkg::NUM_BOARDS; i >= 1; i--)
		begin
			cand = last + i[acq_pkg::BOARD_W-1:0]; // Nearest candidate comes last and wins
			if (mask[cand])
				pick = cand;
		end
		return pick;
	endfunction

	function automatic int pending_words();
		int n;
		n = 0;
		for (int b = 0; b < acq_pkg::NUM_BOARDS; b++)
			n += exp_q[b].size();
		return n;
	endfunction

	function automatic int head_delay(input logic [acq_pkg::BOARD_W-1:0] b);
		if (exp_q[b].size() == 0)
			return 0;
		return exp_q[b][0].delay;
	endfunction

	function automatic int worst_delay();
		int w;
		w = 0;
		for (int r = 0; r < NUM_ROWS; r++)
			if (STIM[r].delay > w)
				w = STIM[r].delay;
		return w;
	endfunction

	task automatic expect_value(input string name, input logic [31:0] got,
		input logic [31:0] want);
		test_checks++;
		assert (got === want)
		else
		begin
			$display("[FAIL] %s: got %h, expected %h", name, got, want);
			test_errs++;
		end
	endtask

	// Holds the sample until a cycle where sample_ready is high
	task automatic send_sample(input logic [acq_pkg::BOARD_W-1:0] board,
		input logic [acq_pkg::CHAN_W-1:0] channel, input logic [acq_pkg::SAMPLE_W-1:0] data);
		int waits;
		waits = 0;
		@(negedge clk);
		sample_in.board   = board;
		sample_in.channel = channel;
		sample_in.data    = data;
		sample_valid      = 1'b1;
		#(CLK_PERIOD / 4);            // Ready settles after the new board is seen
		while (!sample_ready)
		begin
			waits++;
			@(negedge clk);
			#(CLK_PERIOD / 4);
		end
		if (waits > 1)                // A single cycle is only the write still in flight
			stall_cycles += waits;
		@(posedge clk);               // Transfer edge
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Wishbone slave and scoreboard
	////////////////////////////////////////////////////////////////////////////

	// Word is checked when the ack is raised, adr and dat are stable then
	task automatic check_word();
		exp_word_t                   e;
		logic [acq_pkg::BOARD_W-1:0] b;
		b = wb_req.adr.board;
		word_checks++;
		assert (exp_q[b].size() != 0)
		else
		begin
			$display("write to board %0d arrived with no frame of that board pending", b);
			word_errs++;
		end
		if (exp_q[b].size() != 0)
		begin
			e = exp_q[b].pop_front();
			if (e.adr.channel == '0)
			begin
				frame_errs = 0;
				start_order.push_back(b);
			end
			word_checks += 2;
			assert (wb_req.adr == e.adr)
			else
			begin
				$display("[FAIL] wb_req.adr: got %h, expected %h", wb_req.adr, e.adr);
				frame_errs++;
				word_errs++;
			end
			assert (wb_req.dat == e.dat)
			else
			begin
				$display("[FAIL] wb_req.dat: got %h, expected %h", wb_req.dat, e.dat);
				frame_errs++;
				word_errs++;
			end
			if (&e.adr.channel)         // Last word closes the frame
			begin
				frames++;
				$display("frame %0d board %0d offset %0d: %0d mismatches", frames,
					e.adr.board, e.adr.offset, frame_errs);
			end
		end
	endtask

	always @(negedge clk)
	begin
		if (!rst_n)
		begin
			wb_rsp   = '0;
			wait_cnt = 0;
		end
		else if (wb_rsp.ack)
			wb_rsp.ack = 1'b0;          // One cycle pulse, the master drops stb next
		else if (wb_req.stb && !hold_ack)
		begin
			if (wait_cnt < head_delay(wb_req.adr.board))
				wait_cnt++;
			else
			begin
				check_word();
				wb_rsp.ack = 1'b1;
				wait_cnt   = 0;
			end
		end
	end

	// Limit assumes every word waits the longest ack plus gap and settle
	always @(posedge clk)
	begin
		cycles++;
		if (cycles > cycle_limit)
		begin
			$display("timeout after %0d cycles with %0d words still expected", cycle_limit,
				pending_words());
			$display("Simulation failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		exp_word_t                      e;
		int                             errs_before;
		int                             n_rr;
		logic [acq_pkg::BOARD_W-1:0]    rr_last;
		logic [acq_pkg::BOARD_W-1:0]    rr_pick;
		logic [acq_pkg::NUM_BOARDS-1:0] rr_mask;

		cycle_limit  = NUM_ROWS * acq_pkg::NUM_CHANNELS * (worst_delay() + 3) + 200;
		rst_n        = 1'b0;
		sample_in    = '0;
		sample_valid = 1'b0;
		hold_ack     = 1'b0;
		for (int b = 0; b < acq_pkg::NUM_BOARDS; b++)
			exp_off[b] = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		@(negedge clk);
		errs_before = test_errs;
		expect_value("wb_req.cyc", 32'(wb_req.cyc), 32'd0);
		expect_value("wb_req.stb", 32'(wb_req.stb), 32'd0);
		expect_value("sample_ready", 32'(sample_ready), 32'd1);
		$display("reset: %0d mismatches", test_errs - errs_before);

		for (int r = 0; r < NUM_ROWS; r++)
		begin
			if (hold_ack && !STIM[r].hold)
			begin
				repeat (4) @(negedge clk);  // Last held frame reaches ready first
				hold_ack = 1'b0;
			end
			if (STIM[r].hold)
				hold_ack = 1'b1;
			for (int c = 0; c < acq_pkg::NUM_CHANNELS; c++)
			begin
				e.adr.board   = STIM[r].board;
				e.adr.channel = c[acq_pkg::CHAN_W-1:0]; // Drain is always in channel order
				e.adr.offset  = exp_off[STIM[r].board];
				e.dat         = STIM[r].base + c;
				e.delay       = STIM[r].delay;
				exp_q[STIM[r].board].push_back(e);
			end
			exp_off[STIM[r].board] = exp_off[STIM[r].board] + 8'd1;
			shuffle_channels();
			for (int k = 0; k < acq_pkg::NUM_CHANNELS; k++)
				send_sample(STIM[r].board, chan_order[k], STIM[r].base + 32'(chan_order[k]));
		end
		@(negedge clk);
		sample_valid = 1'b0;

		while (pending_words() != 0 || wb_req.cyc)
			@(negedge clk);
		repeat (20) @(negedge clk);     // A stray extra write would raise cyc here
		expect_value("wb_req.cyc", 32'(wb_req.cyc), 32'd0);

		// The first held frame drains alone, the rest follow the rotation
		errs_before = test_errs;
		n_rr        = 0;
		while (n_rr < NUM_ROWS && STIM[n_rr].hold)
			n_rr++;
		rr_last = '1;                   // Pointer value after reset
		rr_mask = '0;
		rr_mask[STIM[0].board] = 1'b1;
		for (int k = 0; k < n_rr; k++)
		begin
			rr_pick = rotate_pick(rr_last, rr_mask);
			expect_value("drain order board", 32'(start_order[k]), 32'(rr_pick));
			rr_mask[rr_pick] = 1'b0;
			if (k == 0)
				for (int m = 1; m < n_rr; m++)
					rr_mask[STIM[m].board] = 1'b1;
			rr_last = rr_pick;
		end
		$display("round-robin: %0d frames, %0d mismatches", n_rr, test_errs - errs_before);

		test_checks++;
		assert (stall_cycles > 0)
		else
		begin
			$display("back-pressure: no sample was ever held off by a full buffer");
			test_errs++;
		end
		$display("back-pressure: %0d stalled cycles", stall_cycles);

		$display("checks %0d, errors %0d, frames %0d of %0d", word_checks + test_checks,
			word_errs + test_errs, frames, NUM_ROWS);
		if (word_errs + test_errs == 0 && frames == NUM_ROWS)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
acq_pkg.sv
mem_pkg.sv
sample_distributor.sv
reorder_buffer.sv
rr_arbiter.sv
dram_write_ctrl.sv
acq_top.sv
acq_properties.sv
tb_acq_top.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module tb_acq_top -o sim_acq
./obj_dir/sim_acq | tee sim.log
if grep -q "Simulation completed successfully" sim.log; then
	echo "run_sim: pass"
else
	echo "run_sim: fail"
	exit 1
fi
